//--- rvPkg.sv
package rvPkg;

	localparam int xLen = 32;
	localparam int memWords = 256; // data memory depth in words

	typedef enum logic [3:0]
	{
		aluAdd,
		aluSub,
		aluSll,
		aluSlt,
		aluSltu,
		aluXor,
		aluSrl,
		aluSra,
		aluOr,
		aluAnd
	} aluOp_t;

	typedef enum logic [2:0]
	{
		brNone,
		brEq,
		brNe,
		brLt,
		brGe,
		brLtu,
		brGeu
	} brCond_t;

	typedef enum logic [2:0]
	{
		mdMul,
		mdMulh,
		mdMulhsu,
		mdMulhu,
		mdDiv,
		mdDivu,
		mdRem,
		mdRemu
	} mulDivOp_t;

	typedef enum logic [3:0]
	{
		memNone,
		memLb,
		memLh,
		memLw,
		memLbu,
		memLhu,
		memSb,
		memSh,
		memSw
	} memOp_t;

	typedef enum logic [2:0]
	{
		wbAlu,
		wbPcPlus4,
		wbMulDiv,
		wbLui,
		wbMem,
		wbAuipc,
		wbCsr
	} wbSel_t;

	// same encoding as funct3 of the system opcode
	typedef enum logic [2:0]
	{
		csrNone = 3'd0,
		csrRw = 3'd1,
		csrRs = 3'd2,
		csrRc = 3'd3,
		csrRwi = 3'd5,
		csrRsi = 3'd6,
		csrRci = 3'd7
	} csrOp_t;

	typedef enum logic [1:0]
	{
		modeUser = 2'd0,
		modeSupervisor = 2'd1,
		modeMachine = 2'd3
	} mode_t;

	// mcause codes without the interrupt bit
	localparam logic [30:0] causeMExtInt = 31'd11;
	localparam logic [30:0] causeSExtInt = 31'd9;
	localparam logic [30:0] causeMTimer = 31'd7;
	localparam logic [30:0] causeSTimer = 31'd5;
	localparam logic [30:0] causeIllegal = 31'd2;
	localparam logic [30:0] causeUserEcall = 31'd8; // plus current mode
	localparam logic [30:0] causeLoadMisalign = 31'd4;
	localparam logic [30:0] causeStoreMisalign = 31'd6;

endpackage

//--- alu.sv
`timescale 1ns/1ps

module alu
(
	input rvPkg::aluOp_t aluOp,
	input rvPkg::brCond_t brCond,
	input logic [rvPkg::xLen-1:0] a,
	input logic [rvPkg::xLen-1:0] b,
	output logic [rvPkg::xLen-1:0] result,
	output logic taken
);

	logic [4:0] shamt;

	assign shamt = b[4:0]; // only low five bits count for rv32

	always_comb
	begin
		case (aluOp)
			rvPkg::aluAdd: result = a + b;
			rvPkg::aluSub: result = a - b;
			rvPkg::aluSll: result = a << shamt;
			rvPkg::aluSlt: result = {31'b0, $signed(a) < $signed(b)};
			rvPkg::aluSltu: result = {31'b0, a < b};
			rvPkg::aluXor: result = a ^ b;
			rvPkg::aluSrl: result = a >> shamt;
			rvPkg::aluSra: result = $signed(a) >>> shamt;
			rvPkg::aluOr: result = a | b;
			rvPkg::aluAnd: result = a & b;
			default: result = '0;
		endcase
	end

	// branch compare runs beside the arithmetic path
	always_comb
	begin
		case (brCond)
			rvPkg::brEq: taken = (a == b);
			rvPkg::brNe: taken = (a != b);
			rvPkg::brLt: taken = $signed(a) < $signed(b);
			rvPkg::brGe: taken = $signed(a) >= $signed(b);
			rvPkg::brLtu: taken = a < b;
			rvPkg::brGeu: taken = a >= b;
			default: taken = 1'b0; // brNone, not a branch
		endcase
	end

endmodule

//--- mulDiv.sv
`timescale 1ns/1ps

module mulDiv
(
	input rvPkg::mulDivOp_t op,
	input logic [rvPkg::xLen-1:0] a,
	input logic [rvPkg::xLen-1:0] b,
	output logic [rvPkg::xLen-1:0] result
);

	logic signed [2*rvPkg::xLen+1:0] prodSS; // one extra bit per operand
	logic signed [2*rvPkg::xLen+1:0] prodSU;
	logic [2*rvPkg::xLen-1:0] prodUU;
	logic divZero;
	logic overflow;

	assign prodSS = $signed({a[rvPkg::xLen-1], a}) * $signed({b[rvPkg::xLen-1], b});
	assign prodSU = $signed({a[rvPkg::xLen-1], a}) * $signed({1'b0, b});
	assign prodUU = a * b;

	assign divZero = (b == '0);
	// most negative value divided by -1
	assign overflow = (a == {1'b1, {(rvPkg::xLen-1){1'b0}}}) && (b == '1);

	always_comb
	begin
		case (op)
			rvPkg::mdMul: result = prodUU[rvPkg::xLen-1:0]; // low word is sign agnostic
			rvPkg::mdMulh: result = prodSS[2*rvPkg::xLen-1:rvPkg::xLen];
			rvPkg::mdMulhsu: result = prodSU[2*rvPkg::xLen-1:rvPkg::xLen];
			rvPkg::mdMulhu: result = prodUU[2*rvPkg::xLen-1:rvPkg::xLen];
			rvPkg::mdDiv:
				if (divZero)
					result = '1;
				else if (overflow)
					result = a;
				else
					result = $signed(a) / $signed(b);
			rvPkg::mdDivu: result = divZero ? '1 : a / b;
			rvPkg::mdRem:
				if (divZero)
					result = a;
				else if (overflow)
					result = '0;
				else
					result = $signed(a) % $signed(b);
			rvPkg::mdRemu: result = divZero ? a : a % b;
			default: result = '0;
		endcase
	end

endmodule

//--- csrUnit.sv
`timescale 1ns/1ps

module csrUnit
(
	input rvPkg::csrOp_t op,
	input logic [rvPkg::xLen-1:0] rs1,
	input logic [rvPkg::xLen-1:0] imm,
	input logic [rvPkg::xLen-1:0] oldValue,
	output logic [rvPkg::xLen-1:0] newValue
);

	logic [rvPkg::xLen-1:0] src;

	// funct3 bit 2 marks the zimm forms
	assign src = op[2] ? imm : rs1;

	always_comb
	begin
		case (op)
			rvPkg::csrRw,
			rvPkg::csrRwi: newValue = src;
			rvPkg::csrRs,
			rvPkg::csrRsi: newValue = oldValue | src; // set bits
			rvPkg::csrRc,
			rvPkg::csrRci: newValue = oldValue & ~src; // clear bits
			default: newValue = oldValue; // csrNone keeps the register
		endcase
	end

endmodule

//--- dataMem.sv
`timescale 1ns/1ps

module dataMem
(
	input logic clk,
	input logic nrst,
	input rvPkg::memOp_t memOp4,
	input logic [rvPkg::xLen-1:0] base,
	input logic [rvPkg::xLen-1:0] regOffset,
	input logic [rvPkg::xLen-1:0] storeOffset,
	input logic [rvPkg::xLen-1:0] storeData,
	output logic [rvPkg::xLen-1:0] memOut6,
	output logic misalign6
);

	logic [rvPkg::xLen-1:0] mem [rvPkg::memWords];
	logic isStore4;
	logic [rvPkg::xLen-1:0] addr4;
	logic [$clog2(rvPkg::memWords)-1:0] wordIdx4;
	logic misalign4;
	logic [3:0] byteEn4;
	logic [rvPkg::xLen-1:0] wrData4;
	logic [rvPkg::xLen-1:0] word5;
	logic [rvPkg::xLen-1:0] word6;
	rvPkg::memOp_t op5;
	rvPkg::memOp_t op6;
	logic [1:0] low5;
	logic [1:0] low6;
	logic misalign5;
	logic [7:0] byte6;
	logic [15:0] half6;

	assign isStore4 = memOp4 inside {rvPkg::memSb, rvPkg::memSh, rvPkg::memSw};
	assign addr4 = base + (isStore4 ? storeOffset : regOffset);
	assign wordIdx4 = addr4[$clog2(rvPkg::memWords)+1:2];

	always_comb
	begin
		case (memOp4)
			rvPkg::memLh,
			rvPkg::memLhu,
			rvPkg::memSh: misalign4 = addr4[0];
			rvPkg::memLw,
			rvPkg::memSw: misalign4 = (addr4[1:0] != 2'b00);
			default: misalign4 = 1'b0;
		endcase
	end

	// byte lanes, nothing written for a misaligned store
	always_comb
	begin
		byteEn4 = 4'b0000;
		wrData4 = storeData;
		case (memOp4)
			rvPkg::memSb:
			begin
				byteEn4 = 4'b0001 << addr4[1:0];
				wrData4 = {4{storeData[7:0]}};
			end
			rvPkg::memSh:
			begin
				byteEn4 = addr4[1] ? 4'b1100 : 4'b0011;
				wrData4 = {2{storeData[15:0]}};
			end
			rvPkg::memSw: byteEn4 = 4'b1111;
			default: byteEn4 = 4'b0000;
		endcase
		if (misalign4)
			byteEn4 = 4'b0000;
	end

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < 4; i++)
			if (byteEn4[i])
				mem[wordIdx4][8*i +: 8] <= wrData4[8*i +: 8];
		word5 <= mem[wordIdx4]; // registered read
		word6 <= word5;
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			op5 <= rvPkg::memNone;
			op6 <= rvPkg::memNone;
			low5 <= 2'b00;
			low6 <= 2'b00;
			misalign5 <= 1'b0;
			misalign6 <= 1'b0;
		end
		else
		begin
			op5 <= memOp4;
			op6 <= op5;
			low5 <= addr4[1:0];
			low6 <= low5;
			misalign5 <= misalign4;
			misalign6 <= misalign5;
		end
	end

	assign byte6 = word6[{low6, 3'b000} +: 8];
	assign half6 = word6[{low6[1], 4'b0000} +: 16];

	always_comb
	begin
		case (op6)
			rvPkg::memLb: memOut6 = {{24{byte6[7]}}, byte6};
			rvPkg::memLbu: memOut6 = {24'b0, byte6};
			rvPkg::memLh: memOut6 = {{16{half6[15]}}, half6};
			rvPkg::memLhu: memOut6 = {16'b0, half6};
			rvPkg::memLw: memOut6 = word6;
			default: memOut6 = '0; // stores and bubbles
		endcase
		if (misalign6)
			memOut6 = '0;
	end

endmodule

//--- exeStage.sv
`timescale 1ns/1ps

module exeStage
(
	input logic clk,
	input logic nrst,
	input logic flush,
	input logic [rvPkg::xLen-1:0] opA,
	input logic [rvPkg::xLen-1:0] opB,
	input logic [4:0] rd4,
	input logic we4,
	input rvPkg::wbSel_t wbSel4,
	input rvPkg::aluOp_t aluOp4,
	input rvPkg::brCond_t brCond4,
	input logic jump4,
	input logic jumpReg4,
	input logic [rvPkg::xLen-1:0] bImm4,
	input logic [rvPkg::xLen-1:0] jImm4,
	input logic [rvPkg::xLen-1:0] uImm4,
	input logic [rvPkg::xLen-1:0] sImm4,
	input logic [rvPkg::xLen-1:0] pc4,
	input rvPkg::memOp_t memOp4,
	input rvPkg::mulDivOp_t mulDivOp4,
	input rvPkg::csrOp_t csrOp4,
	input logic [rvPkg::xLen-1:0] csrData4,
	input logic [rvPkg::xLen-1:0] csrImm4,
	input logic [11:0] csrAddr4,
	input logic csrWe4,
	input logic ecall4,
	input logic illegal4,
	input logic mret4,
	input rvPkg::mode_t currentMode,
	input logic mTimer,
	input logic sTimer,
	input logic extInt,
	input logic mtie,
	input logic stie,
	input logic meie,
	input logic seie,
	output logic [rvPkg::xLen-1:0] target5,
	output logic bjTaken5,
	output logic [rvPkg::xLen-1:0] wbData6,
	output logic we6,
	output logic [4:0] rd6,
	output logic [rvPkg::xLen-1:0] pc6,
	output logic [rvPkg::xLen-1:0] csrWb6,
	output logic [11:0] csrWbAddr6,
	output logic csrWe6,
	output logic exception6,
	output logic [rvPkg::xLen-1:0] cause6,
	output logic mret6
);

	logic [4:0] rd5;
	logic we5, jump5, jumpReg5, csrWe5, ecall5, illegal5, mret5;
	rvPkg::wbSel_t wbSel5, wbSel6;
	rvPkg::aluOp_t aluOp5;
	rvPkg::brCond_t brCond5;
	rvPkg::memOp_t memOp5, memOp6;
	rvPkg::mulDivOp_t mulDivOp5;
	rvPkg::csrOp_t csrOp5;
	logic [rvPkg::xLen-1:0] opA5, opB5, bImm5, jImm5, uImm5, pc5, csrData5, csrImm5;
	logic [11:0] csrAddr5;
	logic [rvPkg::xLen-1:0] aluRes5, mulDivRes5, csrNew5, jrSum5;
	logic aluTaken5;
	logic [rvPkg::xLen-1:0] aluRes6, mulDivRes6, uImm6, auipc6, csrOld6;
	logic ecall6, illegal6;
	logic [rvPkg::xLen-1:0] memOut6;
	logic misalign6;
	logic loadMis6, storeMis6;
	logic lowMode, mExtOn, sExtOn, mTimOn, sTimOn;

	// stage 5 control
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst || flush)
		begin
			rd5 <= 5'd0;
			we5 <= 1'b0;
			wbSel5 <= rvPkg::wbAlu;
			aluOp5 <= rvPkg::aluAdd;
			brCond5 <= rvPkg::brNone;
			jump5 <= 1'b0;
			jumpReg5 <= 1'b0;
			memOp5 <= rvPkg::memNone;
			mulDivOp5 <= rvPkg::mdMul;
			csrOp5 <= rvPkg::csrNone;
			csrWe5 <= 1'b0;
			ecall5 <= 1'b0;
			illegal5 <= 1'b0;
			mret5 <= 1'b0;
		end
		else
		begin
			rd5 <= rd4;
			we5 <= we4;
			wbSel5 <= wbSel4;
			aluOp5 <= aluOp4;
			brCond5 <= brCond4;
			jump5 <= jump4;
			jumpReg5 <= jumpReg4;
			memOp5 <= memOp4;
			mulDivOp5 <= mulDivOp4;
			csrOp5 <= csrOp4;
			csrWe5 <= csrWe4;
			ecall5 <= ecall4;
			illegal5 <= illegal4;
			mret5 <= mret4;
		end
	end

	// stage 5 operands and immediates
	always_ff @(posedge clk)
	begin
		if (flush)
		begin
			opA5 <= '0;
			opB5 <= '0;
			bImm5 <= '0;
			jImm5 <= '0;
			uImm5 <= '0;
			pc5 <= '0;
			csrData5 <= '0;
			csrImm5 <= '0;
			csrAddr5 <= '0;
		end
		else
		begin
			opA5 <= opA;
			opB5 <= opB;
			bImm5 <= bImm4;
			jImm5 <= jImm4;
			uImm5 <= uImm4;
			pc5 <= pc4;
			csrData5 <= csrData4;
			csrImm5 <= csrImm4;
			csrAddr5 <= csrAddr4;
		end
	end

	alu alu0 (.aluOp(aluOp5), .brCond(brCond5), .a(opA5), .b(opB5),
		.result(aluRes5), .taken(aluTaken5));

	mulDiv mulDiv0 (.op(mulDivOp5), .a(opA5), .b(opB5), .result(mulDivRes5));

	csrUnit csrUnit0 (.op(csrOp5), .rs1(opA5), .imm(csrImm5), .oldValue(csrData5),
		.newValue(csrNew5));

	// opB is the store source and also the load offset
	dataMem dataMem0 (.clk(clk), .nrst(nrst), .memOp4(memOp4), .base(opA),
		.regOffset(opB), .storeOffset(sImm4), .storeData(opB),
		.memOut6(memOut6), .misalign6(misalign6));

	assign jrSum5 = opA5 + opB5;

	always_comb
	begin
		if (jumpReg5)
			target5 = {jrSum5[rvPkg::xLen-1:1], 1'b0}; // jalr drops bit 0
		else if (jump5)
			target5 = pc5 + jImm5;
		else
			target5 = pc5 + bImm5;
	end

	assign bjTaken5 = aluTaken5 | jump5 | jumpReg5;

	// stage 6 control
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst || flush)
		begin
			rd6 <= 5'd0;
			we6 <= 1'b0;
			wbSel6 <= rvPkg::wbAlu;
			memOp6 <= rvPkg::memNone;
			csrWe6 <= 1'b0;
			ecall6 <= 1'b0;
			illegal6 <= 1'b0;
			mret6 <= 1'b0;
		end
		else
		begin
			rd6 <= rd5;
			we6 <= we5;
			wbSel6 <= wbSel5;
			memOp6 <= memOp5;
			csrWe6 <= csrWe5;
			ecall6 <= ecall5;
			illegal6 <= illegal5;
			mret6 <= mret5;
		end
	end

	// stage 6 results, pc survives a flush for the trap handler
	always_ff @(posedge clk)
	begin
		pc6 <= pc5;
		if (flush)
		begin
			aluRes6 <= '0;
			mulDivRes6 <= '0;
			uImm6 <= '0;
			auipc6 <= '0;
			csrOld6 <= '0;
			csrWb6 <= '0;
			csrWbAddr6 <= '0;
		end
		else
		begin
			aluRes6 <= aluRes5;
			mulDivRes6 <= mulDivRes5;
			uImm6 <= uImm5;
			auipc6 <= pc5 + uImm5;
			csrOld6 <= csrData5;
			csrWb6 <= csrNew5;
			csrWbAddr6 <= csrAddr5;
		end
	end

	always_comb
	begin
		case (wbSel6)
			rvPkg::wbAlu: wbData6 = aluRes6;
			rvPkg::wbPcPlus4: wbData6 = pc6 + 32'd4;
			rvPkg::wbMulDiv: wbData6 = mulDivRes6;
			rvPkg::wbLui: wbData6 = uImm6;
			rvPkg::wbMem: wbData6 = memOut6;
			rvPkg::wbAuipc: wbData6 = auipc6;
			rvPkg::wbCsr: wbData6 = csrOld6; // old csr value to rd
			default: wbData6 = '0;
		endcase
	end

	// memory flags only count for an op that is still in stage 6
	assign loadMis6 = misalign6 &&
		(memOp6 inside {rvPkg::memLb, rvPkg::memLh, rvPkg::memLw, rvPkg::memLbu, rvPkg::memLhu});
	assign storeMis6 = misalign6 && (memOp6 inside {rvPkg::memSb, rvPkg::memSh, rvPkg::memSw});

	// supervisor interrupts are only taken below machine mode
	assign lowMode = (currentMode == rvPkg::modeUser) || (currentMode == rvPkg::modeSupervisor);
	assign mExtOn = meie && extInt;
	assign sExtOn = lowMode && seie && extInt;
	assign mTimOn = mtie && mTimer;
	assign sTimOn = lowMode && stie && sTimer;

	always_comb
	begin
		cause6 = '0;
		if (mExtOn)
			cause6 = {1'b1, rvPkg::causeMExtInt};
		else if (sExtOn)
			cause6 = {1'b1, rvPkg::causeSExtInt};
		else if (mTimOn)
			cause6 = {1'b1, rvPkg::causeMTimer};
		else if (sTimOn)
			cause6 = {1'b1, rvPkg::causeSTimer};
		else if (ecall6)
			cause6 = {1'b0, rvPkg::causeUserEcall + {29'b0, currentMode}};
		else if (illegal6)
			cause6 = {1'b0, rvPkg::causeIllegal};
		else if (loadMis6)
			cause6 = {1'b0, rvPkg::causeLoadMisalign};
		else if (storeMis6)
			cause6 = {1'b0, rvPkg::causeStoreMisalign};
	end

	assign exception6 = mExtOn | sExtOn | mTimOn | sTimOn | ecall6 | illegal6 |
		loadMis6 | storeMis6 | mret6; // mret also redirects the pc

endmodule

//--- exeStage_properties.sv
`timescale 1ns/1ps

module exeStageAsserts
(
	input logic clk,
	input logic nrst,
	input logic flush,
	input logic we4,
	input logic we6,
	input logic csrWe6,
	input logic exception6,
	input logic [rvPkg::xLen-1:0] cause6
);

	logic writeIssued; // set once a write enters the pipe

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			writeIssued <= 1'b0;
		else if (we4)
			writeIssued <= 1'b1;
	end

	flushClearsWrites: assert property (@(posedge clk) disable iff (!nrst)
		flush |=> (!we6 && !csrWe6))
		else $error("we6 or csrWe6 high after a flush edge");

	noWriteBeforeIssue: assert property (@(posedge clk) disable iff (!nrst)
		!writeIssued |-> !we6)
		else $error("we6 high before any write was issued");

	causeMeansException: assert property (@(posedge clk) disable iff (!nrst)
		(cause6 != '0) |-> exception6)
		else $error("cause6 non-zero with exception6 low");

endmodule

bind exeStage exeStageAsserts asserts0
(
	.clk(clk),
	.nrst(nrst),
	.flush(flush),
	.we4(we4),
	.we6(we6),
	.csrWe6(csrWe6),
	.exception6(exception6),
	.cause6(cause6)
);

//--- exeStage_tb.sv
`timescale 1ns/1ps

module exeStage_tb;

	typedef logic [rvPkg::xLen-1:0] word_t;

	localparam int clkPeriod = 40;
	localparam int resetCycles = 16;
	localparam int numTests = 6;
	localparam int cyclesPerTest = 200;
	localparam word_t signBit = 32'h8000_0000;

	logic clk;
	logic nrst;
	logic flush;
	word_t opA, opB, bImm4, jImm4, uImm4, sImm4, pc4, csrData4, csrImm4;
	logic [4:0] rd4;
	logic we4, jump4, jumpReg4, csrWe4, ecall4, illegal4, mret4;
	rvPkg::wbSel_t wbSel4;
	rvPkg::aluOp_t aluOp4;
	rvPkg::brCond_t brCond4;
	rvPkg::memOp_t memOp4;
	rvPkg::mulDivOp_t mulDivOp4;
	rvPkg::csrOp_t csrOp4;
	logic [11:0] csrAddr4;
	rvPkg::mode_t currentMode;
	logic mTimer, sTimer, extInt, mtie, stie, meie, seie;
	word_t target5, wbData6, pc6, csrWb6, cause6;
	logic bjTaken5, we6, csrWe6, exception6, mret6;
	logic [4:0] rd6;
	logic [11:0] csrWbAddr6;

	int seed;
	int errors;
	int testErrors;
	int failedTests;
	int checks;
	string testName;
	word_t memModel [rvPkg::memWords]; // expected data memory contents

	exeStage dut0 (.*);

	always #(clkPeriod / 2) clk = ~clk;

	// every issue input back to a bubble while interrupt lines stay as they are
	task automatic bubble();
		flush <= 1'b0;
		opA <= '0;
		opB <= '0;
		rd4 <= '0;
		we4 <= 1'b0;
		wbSel4 <= rvPkg::wbAlu;
		aluOp4 <= rvPkg::aluAdd;
		brCond4 <= rvPkg::brNone;
		jump4 <= 1'b0;
		jumpReg4 <= 1'b0;
		bImm4 <= '0;
		jImm4 <= '0;
		uImm4 <= '0;
		sImm4 <= '0;
		pc4 <= '0;
		memOp4 <= rvPkg::memNone;
		mulDivOp4 <= rvPkg::mdMul;
		csrOp4 <= rvPkg::csrNone;
		csrData4 <= '0;
		csrImm4 <= '0;
		csrAddr4 <= '0;
		csrWe4 <= 1'b0;
		ecall4 <= 1'b0;
		illegal4 <= 1'b0;
		mret4 <= 1'b0;
	endtask

	task automatic startIssue();
		@(posedge clk);
		bubble(); // fields set after this land in stage 5 at the next edge
	endtask

	task automatic toStage5();
		@(posedge clk);
		bubble();
		@(negedge clk);
	endtask

	task automatic toStage6();
		@(posedge clk);
		@(negedge clk);
	endtask

	task automatic beginTest(input string name);
		testName = name;
		testErrors = 0;
	endtask

	task automatic endTest();
		if (testErrors == 0)
			$display("test %s: ok", testName);
		else
		begin
			failedTests++;
			$display("test %s: %0d errors", testName, testErrors);
		end
	endtask

	task automatic checkWord(input string what, input word_t expected, input word_t actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			testErrors++;
			$display("ERROR %s %s: expected %h, actual %h", testName, what, expected, actual);
		end
	endtask

	task automatic checkBit(input string what, input logic expected, input logic actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			testErrors++;
			$display("ERROR %s %s: expected %b, actual %b", testName, what, expected, actual);
		end
	endtask

	task automatic checkCause(input string what, input logic isInt, input logic [30:0] code,
		input word_t actual);
		word_t expected;
		expected = {isInt, code};
		checks++;
		if (actual !== expected)
		begin
			errors++;
			testErrors++;
			$display("ERROR %s %s: expected %h, actual %h", testName, what, expected, actual);
		end
	endtask

	function automatic word_t aluModel(input rvPkg::aluOp_t op, input word_t a, input word_t b);
		logic [2*rvPkg::xLen-1:0] signExt;
		word_t biasA;
		word_t biasB;
		signExt = {{rvPkg::xLen{a[rvPkg::xLen-1]}}, a} >> b[4:0];
		biasA = a ^ signBit; // biased compare gives the signed order
		biasB = b ^ signBit;
		case (op)
			rvPkg::aluAdd: return a + b;
			rvPkg::aluSub: return a + ~b + 32'd1;
			rvPkg::aluSll: return a << b[4:0];
			rvPkg::aluSlt: return {31'b0, biasA < biasB};
			rvPkg::aluSltu: return {31'b0, a < b};
			rvPkg::aluXor: return a ^ b;
			rvPkg::aluSrl: return a >> b[4:0];
			rvPkg::aluSra: return signExt[rvPkg::xLen-1:0];
			rvPkg::aluOr: return a | b;
			rvPkg::aluAnd: return a & b;
			default: return '0;
		endcase
	endfunction

	function automatic word_t mulDivModel(input rvPkg::mulDivOp_t op, input word_t a, input word_t b);
		logic [2*rvPkg::xLen-1:0] prod;
		word_t hiSU, hiSS, magA, magB, quo, rem;
		prod = {32'b0, a} * {32'b0, b};
		// signed high words from the unsigned product by correction terms
		hiSU = prod[63:32] - (a[31] ? b : 32'b0);
		hiSS = hiSU - (b[31] ? a : 32'b0);
		magA = a[31] ? -a : a;
		magB = b[31] ? -b : b;
		quo = (a[31] ^ b[31]) ? -(magA / magB) : magA / magB;
		rem = a[31] ? -(magA % magB) : magA % magB;
		case (op)
			rvPkg::mdMul: return prod[31:0];
			rvPkg::mdMulh: return hiSS;
			rvPkg::mdMulhsu: return hiSU;
			rvPkg::mdMulhu: return prod[63:32];
			rvPkg::mdDiv: return (b == '0) ? '1 : quo;
			rvPkg::mdDivu: return (b == '0) ? '1 : a / b;
			rvPkg::mdRem: return (b == '0) ? a : rem;
			rvPkg::mdRemu: return (b == '0) ? a : a % b;
			default: return '0;
		endcase
	endfunction

	function automatic word_t csrModel(input rvPkg::csrOp_t op, input word_t rs1, input word_t imm,
		input word_t old);
		word_t src;
		src = (op == rvPkg::csrRwi || op == rvPkg::csrRsi || op == rvPkg::csrRci) ? imm : rs1;
		case (op)
			rvPkg::csrRw, rvPkg::csrRwi: return src;
			rvPkg::csrRs, rvPkg::csrRsi: return old | src;
			rvPkg::csrRc, rvPkg::csrRci: return old & ~src;
			default: return old;
		endcase
	endfunction

	function automatic logic branchModel(input rvPkg::brCond_t cond, input word_t a, input word_t b);
		logic lessS;
		lessS = (a ^ signBit) < (b ^ signBit);
		case (cond)
			rvPkg::brEq: return a == b;
			rvPkg::brNe: return a != b;
			rvPkg::brLt: return lessS;
			rvPkg::brGe: return !lessS;
			rvPkg::brLtu: return a < b;
			rvPkg::brGeu: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic isMisaligned(input rvPkg::memOp_t op, input word_t addr);
		if (op == rvPkg::memLh || op == rvPkg::memLhu || op == rvPkg::memSh)
			return addr[0];
		if (op == rvPkg::memLw || op == rvPkg::memSw)
			return addr % 4 != 0;
		return 1'b0;
	endfunction

	function automatic word_t modelLoad(input rvPkg::memOp_t op, input word_t addr);
		word_t w;
		logic [7:0] by;
		logic [15:0] hw;
		w = memModel[(addr / 4) % rvPkg::memWords];
		by = w[8*addr[1:0] +: 8];
		hw = w[16*addr[1] +: 16];
		case (op)
			rvPkg::memLb: return {{24{by[7]}}, by};
			rvPkg::memLbu: return {24'b0, by};
			rvPkg::memLh: return {{16{hw[15]}}, hw};
			rvPkg::memLhu: return {16'b0, hw};
			rvPkg::memLw: return w;
			default: return '0;
		endcase
	endfunction

	task automatic storeOp(input rvPkg::memOp_t op, input word_t base, input word_t offset,
		input word_t data);
		word_t addr;
		logic mis;
		int idx;
		addr = base + offset;
		mis = isMisaligned(op, addr);
		idx = (addr / 4) % rvPkg::memWords;
		startIssue();
		memOp4 <= op;
		opA <= base;
		sImm4 <= offset;
		opB <= data;
		toStage5();
		toStage6();
		if (!mis && op == rvPkg::memSb)
			memModel[idx][8*addr[1:0] +: 8] = data[7:0];
		else if (!mis && op == rvPkg::memSh)
			memModel[idx][16*addr[1] +: 16] = data[15:0];
		else if (!mis)
			memModel[idx] = data;
		checkBit("store exception", mis, exception6);
		checkCause("store cause", 1'b0, mis ? rvPkg::causeStoreMisalign : 31'd0, cause6);
	endtask

	task automatic loadOp(input rvPkg::memOp_t op, input word_t base, input word_t offset);
		logic mis;
		mis = isMisaligned(op, base + offset);
		startIssue();
		memOp4 <= op;
		opA <= base;
		opB <= offset;
		we4 <= 1'b1;
		rd4 <= 5'd7;
		wbSel4 <= rvPkg::wbMem;
		toStage5();
		toStage6();
		checkWord("load data", mis ? '0 : modelLoad(op, base + offset), wbData6);
		checkBit("load exception", mis, exception6);
		checkCause("load cause", 1'b0, mis ? rvPkg::causeLoadMisalign : 31'd0, cause6);
	endtask

	task automatic testAlu();
		rvPkg::aluOp_t op;
		word_t a, b, r;
		beginTest("alu");
		op = op.first();
		repeat (op.num())
		begin
			repeat (3)
			begin
				a = $random(seed);
				b = $random(seed);
				r = $random(seed);
				startIssue();
				aluOp4 <= op;
				opA <= a;
				opB <= b;
				we4 <= 1'b1;
				rd4 <= r[4:0];
				wbSel4 <= rvPkg::wbAlu;
				toStage5();
				toStage6();
				checkWord(op.name(), aluModel(op, a, b), wbData6);
				checkBit("we6", 1'b1, we6);
				checkWord("rd6", {27'b0, r[4:0]}, {27'b0, rd6});
			end
			op = op.next();
		end
		endTest();
	endtask

	task automatic runMulDiv(input rvPkg::mulDivOp_t op, input word_t a, input word_t b);
		startIssue();
		mulDivOp4 <= op;
		opA <= a;
		opB <= b;
		we4 <= 1'b1;
		rd4 <= 5'd2;
		wbSel4 <= rvPkg::wbMulDiv;
		toStage5();
		toStage6();
		checkWord(op.name(), mulDivModel(op, a, b), wbData6);
	endtask

	task automatic testMulDiv();
		rvPkg::mulDivOp_t op;
		beginTest("muldiv");
		op = op.first();
		repeat (op.num())
		begin
			repeat (3)
				runMulDiv(op, $random(seed), $random(seed));
			op = op.next();
		end
		runMulDiv(rvPkg::mdDiv, 32'h0000_1234, '0); // divide by zero
		runMulDiv(rvPkg::mdDivu, 32'hffff_fff0, '0);
		runMulDiv(rvPkg::mdRem, 32'h8000_0001, '0);
		runMulDiv(rvPkg::mdRemu, 32'd7, '0);
		runMulDiv(rvPkg::mdDiv, signBit, '1); // signed overflow
		runMulDiv(rvPkg::mdRem, signBit, '1);
		runMulDiv(rvPkg::mdDiv, 32'hffff_fff9, 32'd2);
		runMulDiv(rvPkg::mdRem, 32'hffff_fff9, 32'd2);
		endTest();
	endtask

	task automatic testMemory();
		beginTest("memory");
		storeOp(rvPkg::memSw, 32'h40, 32'h0, 32'h8bad_f00d);
		storeOp(rvPkg::memSw, 32'h40, 32'h4, 32'h1122_3344);
		storeOp(rvPkg::memSh, 32'h40, 32'h6, 32'h0000_c3a5);
		storeOp(rvPkg::memSb, 32'h44, 32'h1, 32'h0000_009e);
		storeOp(rvPkg::memSw, 32'h48, 32'h0, 32'h5a5a_0ff0);
		loadOp(rvPkg::memLw, 32'h40, 32'h0);
		loadOp(rvPkg::memLw, 32'h44, 32'h0);
		loadOp(rvPkg::memLh, 32'h44, 32'h2);
		loadOp(rvPkg::memLhu, 32'h44, 32'h2);
		loadOp(rvPkg::memLh, 32'h40, 32'h0);
		loadOp(rvPkg::memLhu, 32'h40, 32'h2);
		loadOp(rvPkg::memLb, 32'h44, 32'h1);
		loadOp(rvPkg::memLbu, 32'h44, 32'h1);
		loadOp(rvPkg::memLb, 32'h44, 32'h0);
		loadOp(rvPkg::memLbu, 32'h40, 32'h3);
		loadOp(rvPkg::memLh, 32'h40, 32'h1); // odd half address
		storeOp(rvPkg::memSw, 32'h48, 32'h2, 32'hdead_beef);
		loadOp(rvPkg::memLw, 32'h48, 32'h0); // word must be untouched
		endTest();
	endtask

	task automatic runBranch(input rvPkg::brCond_t cond, input word_t a, input word_t b);
		word_t pc, imm;
		pc = $random(seed);
		pc[1:0] = 2'b00;
		imm = $random(seed);
		imm[0] = 1'b0;
		startIssue();
		brCond4 <= cond;
		opA <= a;
		opB <= b;
		pc4 <= pc;
		bImm4 <= imm;
		toStage5();
		checkWord({cond.name(), " target"}, pc + imm, target5);
		checkBit({cond.name(), " taken"}, branchModel(cond, a, b), bjTaken5);
		toStage6();
	endtask

	task automatic runJump(input logic isReg, input word_t a, input word_t b, input word_t pc,
		input word_t imm);
		startIssue();
		jump4 <= !isReg;
		jumpReg4 <= isReg;
		opA <= a;
		opB <= b;
		pc4 <= pc;
		jImm4 <= imm;
		we4 <= 1'b1;
		rd4 <= 5'd1;
		wbSel4 <= rvPkg::wbPcPlus4;
		toStage5();
		checkWord("jump target", isReg ? (a + b) & 32'hffff_fffe : pc + imm, target5);
		checkBit("jump taken", 1'b1, bjTaken5);
		toStage6();
		checkWord("link value", pc + 32'd4, wbData6);
		checkBit("link we6", 1'b1, we6);
	endtask

	task automatic runUpper(input rvPkg::wbSel_t sel, input word_t pc, input word_t imm);
		startIssue();
		wbSel4 <= sel;
		pc4 <= pc;
		uImm4 <= imm;
		we4 <= 1'b1;
		rd4 <= 5'd4;
		toStage5();
		toStage6();
		checkWord(sel.name(), (sel == rvPkg::wbLui) ? imm : pc + imm, wbData6);
	endtask

	task automatic testBranch();
		rvPkg::brCond_t cond;
		beginTest("branch");
		cond = cond.first();
		repeat (cond.num())
		begin
			runBranch(cond, 32'd7, 32'd7);
			runBranch(cond, 32'hffff_fffd, 32'd2);
			runBranch(cond, 32'd2, 32'hffff_fffd);
			cond = cond.next();
		end
		runJump(1'b0, '0, '0, 32'h0000_1000, 32'h0000_0ffc);
		runJump(1'b1, 32'h0000_1001, 32'h0000_0022, 32'h0000_2000, '0); // bit 0 dropped
		runUpper(rvPkg::wbLui, 32'h0000_0100, 32'habcd_e000);
		runUpper(rvPkg::wbAuipc, 32'h0000_2000, 32'h1234_5000);
		endTest();
	endtask

	task automatic testCsr();
		rvPkg::csrOp_t ops [7];
		word_t old, rs1, imm;
		logic [11:0] addr;
		beginTest("csr");
		ops = '{rvPkg::csrNone, rvPkg::csrRw, rvPkg::csrRs, rvPkg::csrRc,
			rvPkg::csrRwi, rvPkg::csrRsi, rvPkg::csrRci};
		foreach (ops[i])
			repeat (2)
			begin
				old = $random(seed);
				rs1 = $random(seed);
				imm = $random(seed) & 32'h1f; // zimm is five bits
				addr = 12'h300 + 12'(i);
				startIssue();
				csrOp4 <= ops[i];
				csrData4 <= old;
				opA <= rs1;
				csrImm4 <= imm;
				csrAddr4 <= addr;
				csrWe4 <= (ops[i] != rvPkg::csrNone);
				we4 <= 1'b1;
				rd4 <= 5'd3;
				wbSel4 <= rvPkg::wbCsr;
				toStage5();
				toStage6();
				checkWord(ops[i].name(), csrModel(ops[i], rs1, imm, old), csrWb6);
				checkWord("csr address", {20'b0, addr}, {20'b0, csrWbAddr6});
				checkBit("csr we", ops[i] != rvPkg::csrNone, csrWe6);
				checkWord("csr old value", old, wbData6);
			end
		endTest();
	endtask

	// lines are extInt, mTimer, sTimer and enables meie, seie, mtie, stie
	task automatic runTrap(input string what, input rvPkg::mode_t md, input logic [2:0] lines,
		input logic [3:0] enables, input logic [2:0] flags, input logic expExc,
		input logic expInt, input logic [30:0] expCode);
		startIssue();
		currentMode <= md;
		{extInt, mTimer, sTimer} <= lines;
		{meie, seie, mtie, stie} <= enables;
		{ecall4, illegal4, mret4} <= flags; // flags are ecall, illegal, mret
		toStage5();
		toStage6();
		checkBit({what, " exception"}, expExc, exception6);
		checkCause({what, " cause"}, expInt, expCode, cause6);
		checkBit({what, " mret6"}, flags[0], mret6);
	endtask

	task automatic testExceptions();
		rvPkg::mode_t modes [3];
		beginTest("exceptions");
		modes = '{rvPkg::modeUser, rvPkg::modeSupervisor, rvPkg::modeMachine};
		foreach (modes[i])
			runTrap("ecall", modes[i], 3'b000, 4'b0000, 3'b100, 1'b1, 1'b0,
				rvPkg::causeUserEcall + {29'b0, modes[i]});
		runTrap("m ext", rvPkg::modeSupervisor, 3'b111, 4'b1111, 3'b010, 1'b1, 1'b1,
			rvPkg::causeMExtInt);
		runTrap("s ext", rvPkg::modeSupervisor, 3'b111, 4'b0111, 3'b010, 1'b1, 1'b1,
			rvPkg::causeSExtInt);
		runTrap("m timer", rvPkg::modeSupervisor, 3'b111, 4'b0011, 3'b010, 1'b1, 1'b1,
			rvPkg::causeMTimer);
		runTrap("s timer", rvPkg::modeSupervisor, 3'b111, 4'b0001, 3'b010, 1'b1, 1'b1,
			rvPkg::causeSTimer);
		runTrap("illegal", rvPkg::modeSupervisor, 3'b111, 4'b0000, 3'b010, 1'b1, 1'b0,
			rvPkg::causeIllegal);
		runTrap("s masked", rvPkg::modeMachine, 3'b111, 4'b0101, 3'b010, 1'b1, 1'b0,
			rvPkg::causeIllegal);
		runTrap("user s timer", rvPkg::modeUser, 3'b001, 4'b0001, 3'b000, 1'b1, 1'b1,
			rvPkg::causeSTimer);
		runTrap("idle masked", rvPkg::modeMachine, 3'b111, 4'b0101, 3'b000, 1'b0, 1'b0, 31'd0);
		runTrap("mret", rvPkg::modeMachine, 3'b000, 4'b0000, 3'b001, 1'b1, 1'b0, 31'd0);

		// flush while the instruction sits in stage 5
		startIssue();
		opA <= 32'd5;
		opB <= 32'd6;
		we4 <= 1'b1;
		rd4 <= 5'd9;
		pc4 <= 32'h0000_3000;
		csrWe4 <= 1'b1;
		illegal4 <= 1'b1; // would trap in stage 6 without the flush
		@(posedge clk);
		bubble();
		flush <= 1'b1;
		@(posedge clk);
		flush <= 1'b0;
		@(negedge clk);
		checkBit("flush we6", 1'b0, we6);
		checkBit("flush csrWe6", 1'b0, csrWe6);
		checkWord("flush rd6", '0, {27'b0, rd6});
		checkWord("flush pc6", 32'h0000_3000, pc6);
		checkBit("flush exception", 1'b0, exception6);
		endTest();
	endtask

	initial
	begin
		#(clkPeriod * (numTests * cyclesPerTest + resetCycles));
		$display("watchdog: tests did not finish within %0d cycles",
			numTests * cyclesPerTest + resetCycles);
		$display("*** FAILED ***");
		$finish;
	end

	initial
	begin
		clk = 1'b0;
		seed = 43476;
		errors = 0;
		failedTests = 0;
		checks = 0;
		nrst <= 1'b0;
		bubble();
		currentMode <= rvPkg::modeMachine;
		{extInt, mTimer, sTimer} <= 3'b000;
		{meie, seie, mtie, stie} <= 4'b0000;
		repeat (resetCycles) @(posedge clk);
		nrst <= 1'b1;
		testAlu();
		testMulDiv();
		testMemory();
		testBranch();
		testCsr();
		testExceptions();
		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			numTests, failedTests, checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- filelist.f
rvPkg.sv
alu.sv
mulDiv.sv
csrUnit.sv
dataMem.sv
exeStage.sv
exeStage_properties.sv
exeStage_tb.sv

//--- run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module exeStage_tb --Mdir "$buildDir" -o exeStageSim -f filelist.f
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
	echo "verilator build failed with status $buildStatus"
	exit 1
fi

"./$buildDir/exeStageSim" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

# the log decides the result
if grep -Fxq '*** PASSED ***' "$logFile"; then
	exit 0
fi
echo "pass message not found in $logFile"
exit 1
